//--- bench/alu_patterns.txt
# name ld op size a b ccr_in result ccr, all hex except the name (ccr bits are X N Z V C)
# ld 1 writes a, b and ccr_in first; ld 0 reuses the stored operands and the current ccr
add_b_carry     1 00 0 123456ff 00000001 00 12345600 15
add_w_ovf       1 00 1 00007fff 00000001 00 00008000 0a
add_l_carry     1 00 2 ffffffff 00000002 00 00000001 11
sub_b_borrow    1 01 0 aaaaaa00 00000001 00 aaaaaaff 19
sub_w_ovf       1 01 1 00008000 00000001 00 00007fff 02
cmp_l_keepx     1 02 2 00000001 00000002 10 00000001 19
addx_l_keepz    1 03 2 ffffffff 00000000 14 00000000 15
addx_b_clrz     1 03 0 00000010 00000020 14 00000031 00
subx_w_borrow   1 04 1 00000000 00000000 14 0000ffff 19
subx_b_keepz    1 04 0 55555505 00000004 14 55555500 04
and_w           1 05 1 fffff0f0 00008f0f 13 ffff8000 18
or_b_zero       1 06 0 12000000 0000ff00 03 12000000 04
eor_l           1 07 2 a5a5a5a5 ffff0000 10 5a5aa5a5 10
move_b          1 08 0 12345678 00000080 07 12345680 08
swap_long       1 09 0 12348765 00000000 1f 87651234 18
btst_bit0       1 0a 2 00000001 00000000 1f 00000001 1b
bchg_bit31      1 0b 2 00000000 0000001f 00 80000000 04
bclr_bit31      1 0c 2 ffffffff 000000ff 10 7fffffff 10
bset_bit0       1 0d 2 00000000 00000020 10 00000001 14
asl_b_ovf       1 0e 0 12345640 00000000 00 12345680 0a
asr_w           1 0f 1 00008001 00000000 00 0000c000 19
lsl_l           1 10 2 80000001 00000000 00 00000002 11
lsr_b_zero      1 11 0 ffffff01 00000000 00 ffffff00 15
rol_w_keepx     1 12 1 00008000 00000000 00 00000001 01
ror_l_keepx     1 13 2 00000001 00000000 10 80000000 19
roxl_b          1 14 0 00000080 00000000 10 00000001 11
roxr_w          1 15 1 00000000 00000000 10 00008000 08
divu_pos        1 16 1 00000064 00000007 10 0002000e 10
divs_neg_a      1 17 1 ffffff9c 00000007 00 fffefff2 08
divs_neg_b      1 17 1 00000064 0000fff9 00 0002fff2 08
divs_ovf        1 17 1 00008000 00000001 00 00008000 02
divu_ovf        1 16 1 00100000 00000010 1f 00100000 12
div_by_zero     1 16 1 12345678 ffff0000 0f 12345678 02
divu_chain      1 16 1 00020001 00000003 10 0000aaab 18
asr_after_div   0 0f 2 00020001 00000003 18 00010000 11
unknown_op      0 1f 2 00020001 00000003 11 00010000 11

//--- bench/alu_tb.sv
/*
 * ALU peripheral testbench
 * Reads operations and expected results from the pattern file, runs
 * them as Wishbone bus cycles and checks the result and ccr registers
 */
`timescale 1ns/100ps
`default_nettype none

module alu_tb
    import alu_pkg::*, wb_regs_pkg::*;
();

localparam int    CLK_HALF     = 2;     // 4 ns period
localparam int    RESET_CYCLES = 8;
localparam int    DRIVE_DELAY  = 1;     // After the rising edge
localparam int    ACK_TIMEOUT  = 64;    // Divides take about 20 cycles
localparam string PATTERN_FILE = "bench/alu_patterns.txt";

logic        clk;
logic        reset;
wb_req_t     bus_req;
wb_rsp_t     bus_rsp;
logic [31:0] rng_state;

always #CLK_HALF clk = ~clk;

alu_top i_alu_top (
    .clk     (clk),
    .reset   (reset),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp)
);

// --------------------
// Helpers
// --------------------
function automatic logic [31:0] next_random(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Ops that leave X alone, so X in maps straight to X out
function automatic logic keeps_x(input logic [4:0] op);
    return op inside {ALU_CMP, ALU_AND, ALU_OR, ALU_EOR, ALU_MOVE, ALU_ROL, ALU_ROR,
                      ALU_BTST, ALU_BCHG, ALU_BCLR, ALU_BSET};
endfunction

task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "Stopping at the first error");
endtask

task automatic check_data(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
        $display("FAILED %s: expected data %h, actual %h", name, expected, actual);
        abort_run();
    end
endtask

task automatic check_ccr(input string name, input ccr_t expected, input ccr_t actual);
    if (actual !== expected) begin
        $display("FAILED %s: expected ccr %h, actual %h", name, expected, actual);
        abort_run();
    end
endtask

task automatic idle_gap();
    rng_state = next_random(rng_state);
    repeat (rng_state[1:0]) @(posedge clk);     // 0 to 3 idle cycles
endtask

// Ack is sampled on the falling edge, away from the DUT's clock edge
task automatic wait_ack(input reg_addr_t adr);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!bus_rsp.ack && cycles < ACK_TIMEOUT) begin
        cycles++;
        @(negedge clk);
    end
    if (!bus_rsp.ack) begin
        $display("Timeout: no ack within %0d cycles at register %0d", ACK_TIMEOUT, adr);
        abort_run();
    end
endtask

// --------------------
// Bus cycles
// --------------------
task automatic bus_write(input reg_addr_t adr, input wb_data_t dat);
    @(posedge clk);
    #DRIVE_DELAY;
    bus_req.cyc = 1'b1;
    bus_req.stb = 1'b1;
    bus_req.we  = 1'b1;
    bus_req.adr = adr;
    bus_req.dat = dat;
    wait_ack(adr);
    @(posedge clk);                 // Hold stb through the ack edge
    #DRIVE_DELAY;
    bus_req.cyc = 1'b0;
    bus_req.stb = 1'b0;
    bus_req.we  = 1'b0;
endtask

task automatic bus_read(input reg_addr_t adr, output wb_data_t dat);
    @(posedge clk);
    #DRIVE_DELAY;
    bus_req.cyc = 1'b1;
    bus_req.stb = 1'b1;
    bus_req.we  = 1'b0;
    bus_req.adr = adr;
    wait_ack(adr);
    dat = bus_rsp.dat;
    @(posedge clk);
    #DRIVE_DELAY;
    bus_req.cyc = 1'b0;
    bus_req.stb = 1'b0;
endtask

task automatic read_expect(input string name, input reg_addr_t adr, input data_t expected);
    wb_data_t rd;
    bus_read(adr, rd);
    check_data(name, expected, rd);
    idle_gap();
endtask

task automatic write_read_back(input string name, input reg_addr_t adr,
                               input wb_data_t wdat, input data_t expected);
    bus_write(adr, wdat);
    idle_gap();
    read_expect(name, adr, expected);
endtask

// One line of the pattern file
task automatic run_pattern(input string name, input logic load_ops, input logic [4:0] op,
                           input logic [1:0] size, input data_t a, input data_t b,
                           input ccr_t ccr_in, input data_t exp_res, input ccr_t exp_ccr);
    wb_data_t cmd;
    wb_data_t rd;
    if (load_ops) begin
        bus_write(REG_OPA, a);
        idle_gap();
        bus_write(REG_OPB, b);
        idle_gap();
        bus_write(REG_CCR, 32'(ccr_in));
        idle_gap();
    end
    cmd = '0;
    cmd[CMD_OP_LSB +: 5]   = op;
    cmd[CMD_SIZE_LSB +: 2] = size;
    bus_write(REG_CMD, cmd);
    idle_gap();
    bus_read(REG_RESULT, rd);
    check_data(name, exp_res, rd);
    idle_gap();
    bus_read(REG_CCR, rd);
    check_ccr(name, exp_ccr, rd[$bits(ccr_t)-1:0]);
    idle_gap();
endtask

// --------------------
// Main sequence
// --------------------
initial begin
    int         fd;
    int         fields;
    int         count;
    string      line;
    string      name;
    logic       load_ops;
    logic [4:0] op;
    logic [1:0] size;
    data_t      a;
    data_t      b;
    ccr_t       ccr_in;
    data_t      exp_res;
    ccr_t       exp_ccr;

    clk       = 1'b0;
    reset     = 1'b1;
    bus_req   = '0;
    rng_state = 32'h91c3_1e43;
    count     = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;

    read_expect("reset_result", REG_RESULT, '0);
    read_expect("reset_ccr", REG_CCR, '0);
    read_expect("reset_opa", REG_OPA, '0);
    read_expect("reset_opb", REG_OPB, '0);
    write_read_back("rw_opa", REG_OPA, 32'hcafe_f00d, 32'hcafe_f00d);
    write_read_back("rw_opb", REG_OPB, 32'h1357_9bdf, 32'h1357_9bdf);
    write_read_back("rw_ccr", REG_CCR, 32'hffff_ffff, 32'h0000_001f);   // Only 5 bits
    write_read_back("rw_result", REG_RESULT, 32'h5a5a_5a5a, 32'h0000_0000);

    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
        $display("Cannot open the pattern file %s", PATTERN_FILE);
        abort_run();
    end
    while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#") begin
            continue;                               // Comment or blank line
        end
        fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h", name, load_ops, op, size,
                         a, b, ccr_in, exp_res, exp_ccr);
        if (fields != 9) begin
            $display("Malformed pattern line: %s", line);
            abort_run();
        end
        run_pattern(name, load_ops, op, size, a, b, ccr_in, exp_res, exp_ccr);
        // Same operation again with X inverted on the way in and out
        if (load_ops && keeps_x(op)) begin
            run_pattern({name, "_xinv"}, 1'b1, op, size, a, b,
                        ccr_in ^ ccr_t'(1 << CCR_X), exp_res,
                        exp_ccr ^ ccr_t'(1 << CCR_X));
        end
        count++;
    end
    $fclose(fd);

    if (count > 0) begin
        $display("Ran %0d patterns", count);
        $display("Simulation passed");
        $finish;
    end else begin
        $display("No patterns found in %s", PATTERN_FILE);
        abort_run();
    end
end

endmodule

`default_nettype wire

//--- build.f
hw/alu_pkg.sv
hw/wb_regs_pkg.sv
hw/alu_addsub.sv
hw/alu_logic.sv
hw/alu_shift.sv
hw/alu_divider.sv
hw/alu_ctrl.sv
hw/alu_top.sv
bench/alu_tb.sv

//--- hw/alu_addsub.sv
/*
 * Add/subtract unit
 * One 33-bit adder serving ADD, SUB, CMP, ADDX and SUBX at byte,
 * word and long size with sized carry and overflow
 */
`timescale 1ns/100ps
`default_nettype none

module alu_addsub
    import alu_pkg::*;
(
    input  alu_req_t req,
    output alu_res_t res
);

logic        sub_op;
logic        ext_op;        // ADDX or SUBX
logic        carry_in;
data_t       b_in;
logic [32:0] sum;
logic        c8;
logic        c16;
logic        carry;
logic        msb_a;
logic        msb_b;
logic        msb_s;
logic        is_zero;

always_comb begin
    sub_op   = req.op inside {ALU_SUB, ALU_CMP, ALU_SUBX};
    ext_op   = req.op inside {ALU_ADDX, ALU_SUBX};
    carry_in = (ext_op & req.ccr[CCR_X]) ^ sub_op;  // Borrow becomes inverted carry
    b_in     = sub_op ? ~req.b : req.b;
    sum      = {1'b0, req.a} + {1'b0, b_in} + {32'b0, carry_in};

    c8  = sum[8] ^ req.a[8] ^ b_in[8];              // Carry out of bit 7
    c16 = sum[16] ^ req.a[16] ^ b_in[16];           // Carry out of bit 15
    case (req.size)
        SIZE_BYTE: carry = c8;
        SIZE_WORD: carry = c16;
        default:   carry = sum[32];
    endcase

    msb_a   = sized_msb(req.a, req.size);
    msb_b   = sized_msb(b_in, req.size);
    msb_s   = sized_msb(sum[31:0], req.size);
    is_zero = sized_zero(sum[31:0], req.size);

    res.data        = sized_merge(req.a, sum[31:0], req.size);
    res.ccr         = req.ccr;
    res.ccr[CCR_N]  = msb_s;
    res.ccr[CCR_Z]  = ext_op ? (is_zero & req.ccr[CCR_Z]) : is_zero;  // Sticky Z
    res.ccr[CCR_V]  = (msb_a ~^ msb_b) & (msb_a ^ msb_s);
    res.ccr[CCR_C]  = carry ^ sub_op;
    if (req.op == ALU_CMP) begin
        res.data = req.a;                           // Compare only sets flags
    end else begin
        res.ccr[CCR_X] = carry ^ sub_op;
    end
end

endmodule

`default_nettype wire

//--- hw/alu_ctrl.sv
/*
 * ALU controller
 * Wishbone slave decode, operand/ccr/result registers and the command
 * FSM. Single-cycle results are taken from the datapath units, divides
 * are handed to the sequential divider.
 */
`timescale 1ns/100ps
`default_nettype none

module alu_ctrl
    import alu_pkg::*, wb_regs_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  wb_req_t  bus_req,
    output wb_rsp_t  bus_rsp,
    output alu_req_t req,
    input  alu_res_t addsub_res,
    input  alu_res_t logic_res,
    input  alu_res_t shift_res,
    input  alu_res_t div_res,
    output logic     div_start,
    input  logic     div_done
);

typedef enum logic [1:0] {
    IDLE,
    DIVIDE,
    ACK
} state_e;

state_e   state;
data_t    opa;
data_t    opb;
data_t    result;
ccr_t     ccr;
logic     access;       // New bus cycle seen
alu_res_t op_res;
logic     op_div;

assign access = (state == IDLE) && bus_req.cyc && bus_req.stb;

// Request is built from the live command word and the stored operands
always_comb begin
    req.op   = alu_op_e'(bus_req.dat[CMD_OP_LSB +: $bits(alu_op_e)]);
    req.size = size_e'(bus_req.dat[CMD_SIZE_LSB +: $bits(size_e)]);
    req.a    = opa;
    req.b    = opb;
    req.ccr  = ccr;
end

// --------------------
// Result selection
// --------------------
always_comb begin
    op_res.data = result;           // Unknown op keeps old state
    op_res.ccr  = ccr;
    op_div      = 1'b0;
    case (req.op)
        ALU_ADD, ALU_SUB, ALU_CMP, ALU_ADDX, ALU_SUBX:
            op_res = addsub_res;
        ALU_AND, ALU_OR, ALU_EOR, ALU_MOVE, ALU_SWAP,
        ALU_BTST, ALU_BCHG, ALU_BCLR, ALU_BSET:
            op_res = logic_res;
        ALU_ASL, ALU_ASR, ALU_LSL, ALU_LSR,
        ALU_ROL, ALU_ROR, ALU_ROXL, ALU_ROXR:
            op_res = shift_res;
        ALU_DIVU, ALU_DIVS:
            op_div = 1'b1;
        default: ;
    endcase
end

// --------------------
// Command FSM
// --------------------
always_ff @(posedge clk) begin
    if (reset) begin
        state     <= IDLE;
        div_start <= 1'b0;
        opa       <= '0;
        opb       <= '0;
        result    <= '0;
        ccr       <= '0;
    end else begin
        div_start <= 1'b0;
        case (state)
            IDLE: begin
                if (access) begin
                    state <= ACK;
                    if (bus_req.we) begin
                        case (bus_req.adr)
                            REG_OPA: opa <= bus_req.dat;
                            REG_OPB: opb <= bus_req.dat;
                            REG_CCR: ccr <= bus_req.dat[$bits(ccr_t)-1:0];
                            REG_CMD: begin
                                if (op_div) begin
                                    state     <= DIVIDE;
                                    div_start <= 1'b1;
                                end else begin
                                    result <= op_res.data;
                                    ccr    <= op_res.ccr;
                                end
                            end
                            default: ;          // Result register ignores writes
                        endcase
                    end
                end
            end
            DIVIDE: begin
                if (div_done) begin
                    result <= div_res.data;
                    ccr    <= div_res.ccr;
                    state  <= ACK;
                end
            end
            ACK: state <= IDLE;
            default: state <= IDLE;
        endcase
    end
end

// Read data follows the address held by the master
always_comb begin
    bus_rsp.ack = (state == ACK);
    case (bus_req.adr)
        REG_OPA:    bus_rsp.dat = opa;
        REG_OPB:    bus_rsp.dat = opb;
        REG_RESULT: bus_rsp.dat = result;
        REG_CCR:    bus_rsp.dat = {{(32 - $bits(ccr_t)){1'b0}}, ccr};
        default:    bus_rsp.dat = '0;
    endcase
end

// --------------------
// Bus protocol checks
// --------------------
ack_needs_stb: assert property (@(posedge clk) disable iff (reset)
    bus_rsp.ack |-> bus_req.stb);

ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
    bus_rsp.ack |=> !bus_rsp.ack);

endmodule

`default_nettype wire

//--- hw/alu_divider.sv
/*
 * Sequential divider
 * DIVU.W and DIVS.W on a 32-bit dividend and 16-bit divisor with a
 * restoring subtract-shift loop, sign fix-up and overflow detection
 */
`timescale 1ns/100ps
`default_nettype none

module alu_divider
    import alu_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  alu_req_t req,
    output logic     done,
    output alu_res_t res
);

typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_FIX
} div_state_e;

div_state_e                   state;
logic [$clog2(DIV_STEPS)-1:0] step;
logic                         divs_req;
logic                         a_neg;
logic                         b_neg;
data_t                        a_mag;
logic [15:0]                  b_mag;
logic [15:0]                  divisor;      // Divisor magnitude
logic [16:0]                  rem;          // Partial remainder
logic [15:0]                  quo;          // Dividend bits out, quotient bits in
data_t                        dividend;     // Returned unchanged on overflow
logic                         x_flag;
logic                         signed_op;
logic                         neg_quo;
logic                         neg_rem;
logic                         big_quo;      // Quotient wider than 16 bits
logic [16:0]                  shifted;
logic [17:0]                  trial;
logic [15:0]                  quo_out;
logic [15:0]                  rem_out;
logic                         ovf;
alu_res_t                     fix_res;

assign divs_req = (req.op == ALU_DIVS);
assign a_neg    = divs_req & req.a[31];
assign b_neg    = divs_req & req.b[15];
assign a_mag    = a_neg ? -req.a : req.a;
assign b_mag    = b_neg ? -req.b[15:0] : req.b[15:0];

assign shifted = {rem[15:0], quo[15]};
assign trial   = {1'b0, shifted} - {2'b00, divisor};

// --------------------
// Sign fix-up
// --------------------
always_comb begin
    quo_out = neg_quo ? -quo : quo;             // Truncates toward zero
    rem_out = neg_rem ? -rem[15:0] : rem[15:0]; // Remainder follows dividend
    if (big_quo) begin
        ovf = 1'b1;                             // Also covers a zero divisor
    end else if (signed_op) begin
        ovf = neg_quo ? (quo > 16'h8000) : quo[15];
    end else begin
        ovf = 1'b0;
    end

    fix_res.ccr        = '0;
    fix_res.ccr[CCR_X] = x_flag;
    if (ovf) begin
        fix_res.data       = dividend;
        fix_res.ccr[CCR_V] = 1'b1;
    end else begin
        fix_res.data       = {rem_out, quo_out};
        fix_res.ccr[CCR_N] = quo_out[15];
        fix_res.ccr[CCR_Z] = (quo_out == 16'h0000);
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        state <= DIV_IDLE;
        step  <= '0;
        done  <= 1'b0;
    end else begin
        done <= 1'b0;
        case (state)
            DIV_IDLE: begin
                step <= '0;
                if (start) begin
                    state <= DIV_RUN;
                end
            end
            DIV_RUN: begin
                step <= step + 1'b1;
                if (step == $bits(step)'(DIV_STEPS - 1)) begin
                    state <= DIV_FIX;
                end
            end
            DIV_FIX: begin
                state <= DIV_IDLE;
                done  <= 1'b1;
            end
            default: state <= DIV_IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (start) begin
        divisor   <= b_mag;
        rem       <= {1'b0, a_mag[31:16]};
        quo       <= a_mag[15:0];
        dividend  <= req.a;
        x_flag    <= req.ccr[CCR_X];
        signed_op <= divs_req;
        neg_quo   <= a_neg ^ b_neg;
        neg_rem   <= a_neg;
        big_quo   <= (a_mag[31:16] >= b_mag);
    end else if (state == DIV_RUN) begin
        if (!trial[17]) begin
            rem <= trial[16:0];
            quo <= {quo[14:0], 1'b1};
        end else begin
            rem <= shifted;                     // Restore
            quo <= {quo[14:0], 1'b0};
        end
    end
    if (state == DIV_FIX) begin
        res <= fix_res;
    end
end

start_when_idle: assert property (@(posedge clk) disable iff (reset)
    start |-> (state == DIV_IDLE));

endmodule

`default_nettype wire

//--- hw/alu_logic.sv
/*
 * Logic and bit unit
 * AND, OR, EOR, MOVE and SWAP with sized N/Z, plus BTST, BCHG,
 * BCLR and BSET on one bit of operand A
 */
`timescale 1ns/100ps
`default_nettype none

module alu_logic
    import alu_pkg::*;
(
    input  alu_req_t req,
    output alu_res_t res
);

data_t   logic_val;
size_e   eff_size;
bitnum_t bit_pos;
logic    old_bit;
data_t   bit_val;

always_comb begin
    case (req.op)
        ALU_AND:  logic_val = req.a & req.b;
        ALU_OR:   logic_val = req.a | req.b;
        ALU_EOR:  logic_val = req.a ^ req.b;
        ALU_MOVE: logic_val = req.b;
        default:  logic_val = {req.a[15:0], req.a[31:16]};  // SWAP
    endcase
    eff_size = (req.op == ALU_SWAP) ? SIZE_LONG : req.size;

    bit_pos = req.b[4:0];
    old_bit = req.a[bit_pos];
    bit_val = req.a;
    case (req.op)
        ALU_BCHG: bit_val[bit_pos] = ~old_bit;
        ALU_BCLR: bit_val[bit_pos] = 1'b0;
        ALU_BSET: bit_val[bit_pos] = 1'b1;
        default: ;
    endcase

    res.data = req.a;
    res.ccr  = req.ccr;
    if (req.op inside {ALU_AND, ALU_OR, ALU_EOR, ALU_MOVE, ALU_SWAP}) begin
        res.data       = sized_merge(req.a, logic_val, eff_size);
        res.ccr[CCR_N] = sized_msb(logic_val, eff_size);
        res.ccr[CCR_Z] = sized_zero(logic_val, eff_size);
        res.ccr[CCR_V] = 1'b0;
        res.ccr[CCR_C] = 1'b0;
    end else if (req.op inside {ALU_BTST, ALU_BCHG, ALU_BCLR, ALU_BSET}) begin
        res.data       = bit_val;       // BTST leaves A as is
        res.ccr[CCR_Z] = ~old_bit;
    end
end

endmodule

`default_nettype wire

//--- hw/alu_pkg.sv
/*
 * ALU package
 * Data types, operation and size encodings and the request and result
 * structs shared by the controller and the datapath units
 */
`default_nettype none

package alu_pkg;

typedef logic [31:0] data_t;
typedef logic [4:0]  ccr_t;     // X N Z V C
typedef logic [4:0]  bitnum_t;

localparam int CCR_X = 4;
localparam int CCR_N = 3;
localparam int CCR_Z = 2;
localparam int CCR_V = 1;
localparam int CCR_C = 0;

localparam int DIV_STEPS = 16;  // Quotient bits per divide

typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_WORD = 2'd1,
    SIZE_LONG = 2'd2            // 3 also decodes as long
} size_e;

typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,  ALU_SUB  = 5'd1,  ALU_CMP  = 5'd2,  ALU_ADDX = 5'd3,
    ALU_SUBX = 5'd4,  ALU_AND  = 5'd5,  ALU_OR   = 5'd6,  ALU_EOR  = 5'd7,
    ALU_MOVE = 5'd8,  ALU_SWAP = 5'd9,  ALU_BTST = 5'd10, ALU_BCHG = 5'd11,
    ALU_BCLR = 5'd12, ALU_BSET = 5'd13, ALU_ASL  = 5'd14, ALU_ASR  = 5'd15,
    ALU_LSL  = 5'd16, ALU_LSR  = 5'd17, ALU_ROL  = 5'd18, ALU_ROR  = 5'd19,
    ALU_ROXL = 5'd20, ALU_ROXR = 5'd21, ALU_DIVU = 5'd22, ALU_DIVS = 5'd23
} alu_op_e;

typedef struct packed {
    alu_op_e op;
    size_e   size;
    data_t   a;                 // Destination operand
    data_t   b;
    ccr_t    ccr;
} alu_req_t;

typedef struct packed {
    data_t data;
    ccr_t  ccr;
} alu_res_t;

// --------------------
// Sized helpers
// --------------------
function automatic logic sized_msb(data_t d, size_e s);
    case (s)
        SIZE_BYTE: return d[7];
        SIZE_WORD: return d[15];
        default:   return d[31];
    endcase
endfunction

function automatic logic sized_zero(data_t d, size_e s);
    case (s)
        SIZE_BYTE: return d[7:0] == 8'h00;
        SIZE_WORD: return d[15:0] == 16'h0000;
        default:   return d == 32'h0000_0000;
    endcase
endfunction

// Low part from r, upper bits kept from a
function automatic data_t sized_merge(data_t a, data_t r, size_e s);
    case (s)
        SIZE_BYTE: return {a[31:8], r[7:0]};
        SIZE_WORD: return {a[31:16], r[15:0]};
        default:   return r;
    endcase
endfunction

endpackage

`default_nettype wire

//--- hw/alu_shift.sv
/*
 * Shift and rotate unit
 * Moves the sized operand A by one position for ASx, LSx, ROx and ROXx
 * and derives X, C and the ASL overflow
 */
`timescale 1ns/100ps
`default_nettype none

module alu_shift
    import alu_pkg::*;
(
    input  alu_req_t req,
    output alu_res_t res
);

logic  top_bit;     // Sized msb of A
logic  shift_left;
logic  keep_x;
logic  fill;        // Bit entering the vacated position
logic  out_bit;
data_t moved;
data_t shifted;

always_comb begin
    top_bit    = sized_msb(req.a, req.size);
    shift_left = req.op inside {ALU_ASL, ALU_LSL, ALU_ROL, ALU_ROXL};
    keep_x     = req.op inside {ALU_ROL, ALU_ROR};
    case (req.op)
        ALU_ASR:            fill = top_bit;
        ALU_ROL:            fill = top_bit;
        ALU_ROR:            fill = req.a[0];
        ALU_ROXL, ALU_ROXR: fill = req.ccr[CCR_X];  // Rotate through X
        default:            fill = 1'b0;
    endcase

    if (shift_left) begin
        moved   = {req.a[30:0], fill};
        out_bit = top_bit;
    end else begin
        moved = {1'b0, req.a[31:1]};
        case (req.size)
            SIZE_BYTE: moved[7] = fill;
            SIZE_WORD: moved[15] = fill;
            default:   moved[31] = fill;
        endcase
        out_bit = req.a[0];
    end
    shifted = sized_merge(req.a, moved, req.size);

    res.data       = shifted;
    res.ccr        = req.ccr;
    res.ccr[CCR_N] = sized_msb(shifted, req.size);
    res.ccr[CCR_Z] = sized_zero(shifted, req.size);
    res.ccr[CCR_C] = out_bit;
    // ASL overflows when the sign bit flips
    res.ccr[CCR_V] = (req.op == ALU_ASL) & (sized_msb(shifted, req.size) ^ top_bit);
    if (!keep_x) begin
        res.ccr[CCR_X] = out_bit;
    end
end

endmodule

`default_nettype wire

//--- hw/alu_top.sv
/*
 * ALU peripheral top level
 * Wishbone slave with the controller and the four datapath units
 */
`timescale 1ns/100ps
`default_nettype none

module alu_top
    import alu_pkg::*, wb_regs_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  wb_req_t bus_req,
    output wb_rsp_t bus_rsp
);

alu_req_t req;          // Shared by all datapath units
alu_res_t addsub_res;
alu_res_t logic_res;
alu_res_t shift_res;
alu_res_t div_res;
logic     div_start;
logic     div_done;

alu_ctrl i_alu_ctrl (
    .clk        (clk),
    .reset      (reset),
    .bus_req    (bus_req),
    .bus_rsp    (bus_rsp),
    .req        (req),
    .addsub_res (addsub_res),
    .logic_res  (logic_res),
    .shift_res  (shift_res),
    .div_res    (div_res),
    .div_start  (div_start),
    .div_done   (div_done)
);

alu_addsub i_alu_addsub (.req(req), .res(addsub_res));
alu_logic  i_alu_logic  (.req(req), .res(logic_res));
alu_shift  i_alu_shift  (.req(req), .res(shift_res));

alu_divider i_alu_divider (
    .clk   (clk),
    .reset (reset),
    .start (div_start),
    .req   (req),
    .done  (div_done),
    .res   (div_res)
);

endmodule

`default_nettype wire

//--- hw/wb_regs_pkg.sv
/*
 * Wishbone register package
 * Classic bus request and response structs and the register map
 * of the ALU peripheral
 */
`default_nettype none

package wb_regs_pkg;

typedef logic [2:0]  reg_addr_t;    // Word address
typedef logic [31:0] wb_data_t;

localparam reg_addr_t REG_OPA    = 3'd0;   // Destination operand
localparam reg_addr_t REG_OPB    = 3'd1;
localparam reg_addr_t REG_CMD    = 3'd2;
localparam reg_addr_t REG_RESULT = 3'd3;   // Read only
localparam reg_addr_t REG_CCR    = 3'd4;

localparam int CMD_OP_LSB   = 0;
localparam int CMD_SIZE_LSB = 8;

typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    reg_addr_t adr;
    wb_data_t  dat;
} wb_req_t;

typedef struct packed {
    logic     ack;
    wb_data_t dat;
} wb_rsp_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module alu_tb -f build.f -o alu_sim
./obj_dir/alu_sim | tee sim.log

if grep -qx "Simulation passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
